// ==== all.f ====
+incdir+logic
+incdir+dv
logic/fmulPkg.sv
logic/holdPipe.sv
logic/fmulProduct.sv
logic/fmulRound.sv
logic/inflightCounter.sv
logic/fmulIssueCtrl.sv
logic/fmulUnit.sv
dv/fmulUnitTb.sv

// ==== dv/fmulModel.svh ====
// reference model for the double precision multiply unit
// exact product, rounding by mode, special operands and range limits
`ifndef FMUL_MODEL_SVH
`define FMUL_MODEL_SVH

`include "fmulUnit_params.svh"

// returns {result, invalid, overflow, underflow, inexact}
function automatic logic [67:0] fmulModel(
	input logic [63:0]         a,
	input logic [63:0]         b,
	input fmulPkg::roundMode_t rm
);
	logic         sign;
	logic         zeroA;
	logic         zeroB;
	logic         infA;
	logic         infB;
	logic         nanA;
	logic         nanB;
	logic         badMix;
	logic [105:0] prod;
	logic [105:0] rem;
	logic [105:0] half;
	logic [53:0]  sig;
	int           shift;
	int           expo;
	logic         up;

	sign = a[63] ^ b[63];
	// exponent field 0 is zero, fraction ignored
	zeroA = (a[62:52] == 11'd0);
	zeroB = (b[62:52] == 11'd0);
	infA = (a[62:52] == 11'h7FF) && (a[51:0] == 52'd0);
	infB = (b[62:52] == 11'h7FF) && (b[51:0] == 52'd0);
	nanA = (a[62:52] == 11'h7FF) && !infA;
	nanB = (b[62:52] == 11'h7FF) && !infB;
	badMix = (zeroA && infB) || (infA && zeroB);

	if (nanA || nanB || badMix)
		return {`FMUL_QNAN, badMix, 3'b000};
	if (infA || infB)
		return {sign, 11'h7FF, 52'd0, 4'b0000};
	if (zeroA || zeroB)
		return {sign, 63'd0, 4'b0000};

	// full significand product, value in [1,4)
	prod = {53'd0, 1'b1, a[51:0]} * {53'd0, 1'b1, b[51:0]};
	expo = int'(a[62:52]) + int'(b[62:52]) - `FMUL_BIAS;
	shift = prod[105] ? 53 : 52;
	if (prod[105])
		expo = expo + 1;

	// kept part and dropped part, compared against one half ulp
	sig = 54'(prod >> shift);
	half = 106'd1 << (shift - 1);
	rem = prod & ((half << 1) - 106'd1);

	case (rm)
		fmulPkg::rmNearestEven: up = (rem > half) || ((rem == half) && sig[0]);
		fmulPkg::rmTowardZero:  up = 1'b0;
		fmulPkg::rmTowardPos:   up = !sign && (rem != '0);
		default:                up = sign && (rem != '0);
	endcase

	sig = sig + 54'(up);
	// rounded up to 2.0
	if (sig[53])
	begin
		sig = sig >> 1;
		expo = expo + 1;
	end

	if (expo >= 2047)
		return {sign, 11'h7FF, 52'd0, 4'b0101};
	// no denormals, flush to signed zero
	if (expo <= 0)
		return {sign, 63'd0, 4'b0011};
	return {sign, 11'(expo), sig[51:0], 3'b000, (rem != '0)};
endfunction

`endif

// ==== dv/fmulUnitTb.sv ====
// testbench for the double precision multiply unit
// random operands, hold and quiesce, checked against a reference model
`timescale 1ns/1ps
`include "fmulUnit_params.svh"

module fmulUnitTb;
	import fmulPkg::*;

	`include "fmulModel.svh"

	localparam int numCycles    = 4000;
	localparam int quietTimeout = 200;
	localparam int drainTimeout = 100;

	logic        clock;
	logic        rstN;
	logic        start;
	logic [63:0] opA;
	logic [63:0] opB;
	roundMode_t  mode;
	logic        hold;
	logic        quiesce;
	logic [63:0] result;
	fmulFlags_t  flags;
	logic        done;
	logic        ready;
	logic        quiet;

	integer      seed = 83;
	logic        quiesceLevel;

	// expected results in acceptance order, with the move count at acceptance
	logic [67:0] expQ [$];
	int          stampQ [$];
	logic [67:0] expected;
	int          stamp;
	int          moveEdges;
	logic        prevHold;
	logic        prevQuiesce;
	logic [63:0] prevResult;
	fmulFlags_t  prevFlags;
	int          acceptCount;
	int          doneCount;
	int          valueErrors;
	int          protocolErrors;

	fmulUnit u_fmulUnit (
		.clock   (clock),
		.rstN    (rstN),
		.start   (start),
		.opA     (opA),
		.opB     (opB),
		.mode    (mode),
		.hold    (hold),
		.quiesce (quiesce),
		.result  (result),
		.flags   (flags),
		.done    (done),
		.ready   (ready),
		.quiet   (quiet)
	);

	always #4 clock = ~clock;

	function automatic int randBelow(input int n);
		int r;
		r = $random(seed);
		return (r & 32'h7FFF_FFFF) % n;
	endfunction

	// a quarter special exponents, some near the range limits
	function automatic logic [63:0] randOperand();
		int          pick;
		logic [63:0] raw;
		logic [10:0] e;
		logic [51:0] f;
		pick = randBelow(16);
		raw = {$random(seed), $random(seed)};
		f = raw[51:0];
		if (pick < 2)
			e = 11'd0;
		else if (pick < 4)
			e = 11'h7FF;
		else if (pick < 6)
			e = 11'(1530 + randBelow(12));
		else if (pick < 8)
			e = 11'(506 + randBelow(12));
		else
			e = 11'(1 + randBelow(2046));
		// true zero and infinity, nan keeps a set bit
		if (pick == 0 || pick == 2)
			f = 52'd0;
		else if (pick == 3)
			f[0] = 1'b1;
		else if (randBelow(8) == 0)
			f[31:0] = 32'd0;
		// near 2.0 and near 1.0 so rounding can carry out to 2.0
		else if (randBelow(3) == 0)
			f = ~{51'd0, raw[52]};
		else if (randBelow(3) == 0)
			f = {51'd0, raw[52]};
		return {raw[63], e, f};
	endfunction

	task automatic driveRandom();
		@(posedge clock);
		start   <= (randBelow(10) < 6);
		opA     <= randOperand();
		opB     <= randOperand();
		mode    <= roundMode_t'(2'(randBelow(4)));
		hold    <= (randBelow(10) < 2);
		quiesce <= quiesceLevel;
	endtask

	// drain request, then wait for quiet and stay quiet a while
	task automatic runQuiesce();
		int   waited;
		int   linger;
		logic quietSeen;
		quiesceLevel = 1'b1;
		waited = 0;
		quietSeen = 1'b0;
		while (!quietSeen && waited < quietTimeout)
		begin
			driveRandom();
			@(negedge clock);
			quietSeen = quiet;
			waited++;
		end
		assert (quietSeen)
		else
		begin
			$display("quiet did not rise within %0d cycles of a quiesce request at %0t",
				quietTimeout, $time);
			protocolErrors++;
		end
		linger = 5 + randBelow(30);
		for (int i = 0; i < linger; i++)
		begin
			driveRandom();
		end
		quiesceLevel = 1'b0;
	endtask

	// sampled mid cycle, inputs and outputs both settled
	always @(negedge clock)
	begin
		if (rstN)
		begin
			// a held edge leaves the outputs alone
			if (prevHold)
			begin
				assert (result == prevResult)
				else
				begin
					$display("[FAIL] t=%0t result expected=%h actual=%h", $time,
						prevResult, result);
					valueErrors++;
				end
				assert (flags == prevFlags)
				else
				begin
					$display("[FAIL] t=%0t flags expected=%b actual=%b", $time,
						prevFlags, flags);
					valueErrors++;
				end
			end
			if (hold)
			begin
				assert (!done)
				else
				begin
					$display("[FAIL] t=%0t done expected=0 actual=%b", $time, done);
					valueErrors++;
				end
			end
			// ready follows quiesce by one edge
			assert (ready == !prevQuiesce)
			else
			begin
				$display("[FAIL] t=%0t ready expected=%b actual=%b", $time, !prevQuiesce, ready);
				valueErrors++;
			end
			if (quiet)
			begin
				assert (expQ.size() == 0 && prevQuiesce)
				else
				begin
					$display("quiet high at %0t with %0d results outstanding or no quiesce",
						$time, expQ.size());
					protocolErrors++;
				end
			end
			if (done)
			begin
				assert (expQ.size() != 0)
				else
				begin
					$display("done pulse at %0t with no operation outstanding", $time);
					protocolErrors++;
				end
				if (expQ.size() != 0)
				begin
					expected = expQ.pop_front();
					stamp = stampQ.pop_front();
					doneCount++;
					assert (result == expected[67:4])
					else
					begin
						$display("[FAIL] t=%0t result expected=%h actual=%h", $time,
							expected[67:4], result);
						valueErrors++;
					end
					assert (flags == expected[3:0])
					else
					begin
						$display("[FAIL] t=%0t flags expected=%b actual=%b", $time,
							expected[3:0], flags);
						valueErrors++;
					end
					// four moving edges from accept to done
					assert (moveEdges - stamp == `FMUL_LATENCY)
					else
					begin
						$display("[FAIL] t=%0t done latency expected=%0d actual=%0d", $time,
							`FMUL_LATENCY, moveEdges - stamp);
						valueErrors++;
					end
				end
			end
			// predicted accept
			if (start && ready && !hold)
			begin
				expQ.push_back(fmulModel(opA, opB, mode));
				stampQ.push_back(moveEdges);
				acceptCount++;
			end
			if (!hold)
				moveEdges++;
		end
		prevHold = hold;
		prevQuiesce = quiesce;
		prevResult = result;
		prevFlags = flags;
	end

	initial
	begin
		int waited;
		clock = 1'b0;
		rstN = 1'b0;
		start = 1'b0;
		opA = '0;
		opB = '0;
		mode = rmNearestEven;
		hold = 1'b0;
		quiesce = 1'b0;
		quiesceLevel = 1'b0;
		moveEdges = 0;
		prevHold = 1'b0;
		prevQuiesce = 1'b0;
		prevResult = '0;
		prevFlags = '0;
		acceptCount = 0;
		doneCount = 0;
		valueErrors = 0;
		protocolErrors = 0;

		repeat (5) @(posedge clock);
		rstN <= 1'b1;
		@(negedge clock);
		assert (!done && !quiet && ready)
		else
		begin
			$display("after reset done=%b quiet=%b ready=%b, expected 0 0 1", done, quiet, ready);
			protocolErrors++;
		end

		for (int cycle = 0; cycle < numCycles; cycle++)
		begin
			if (randBelow(150) == 0)
				runQuiesce();
			else
				driveRandom();
		end

		// stop issuing and let the pipe empty
		@(posedge clock);
		start <= 1'b0;
		hold <= 1'b0;
		quiesce <= 1'b0;
		waited = 0;
		while (expQ.size() != 0 && waited < drainTimeout)
		begin
			@(posedge clock);
			waited++;
		end
		assert (expQ.size() == 0)
		else
		begin
			$display("%0d results never completed within %0d cycles", expQ.size(), drainTimeout);
			protocolErrors++;
		end
		// idle cycles to catch stray done pulses
		repeat (8) @(posedge clock);

		$display("accepted %0d, completed %0d, value errors %0d, protocol errors %0d",
			acceptCount, doneCount, valueErrors, protocolErrors);
		if (valueErrors == 0 && protocolErrors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// ==== logic/fmulIssueCtrl.sv ====
// issue control FSM for the multiply unit
// gates start into accept, drains on quiesce and reports quiet
`timescale 1ns/1ps
`include "fmulUnit_params.svh"

module fmulIssueCtrl (
	input  logic                     clock,
	input  logic                     rstN,
	input  logic                     start,
	input  logic                     hold,
	input  logic                     quiesce,
	input  logic [`FMUL_COUNT_W-1:0] count,
	output logic                     accept,
	output logic                     ready,
	output logic                     quiet
);
	import fmulPkg::*;

	ctrlState_t state;
	ctrlState_t stateNext;

	// hold stalls the whole pipe, so no new work then
	assign accept = start & ready & ~hold;

	always_comb
	begin
		stateNext = state;
		case (state)
			csRun:
			begin
				if (quiesce)
					stateNext = csDrain;
			end
			csDrain:
			begin
				// quiesce dropped early, go straight back
				if (!quiesce)
					stateNext = csRun;
				else if (count == '0)
					stateNext = csQuiet;
			end
			csQuiet:
			begin
				if (!quiesce)
					stateNext = csRun;
			end
			default:
				stateNext = csRun;
		endcase
	end

	// ready and quiet registered, follow the next state
	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			state <= csRun;
			ready <= 1'b1;
			quiet <= 1'b0;
		end
		else
		begin
			state <= stateNext;
			ready <= (stateNext == csRun);
			quiet <= (stateNext == csQuiet);
		end
	end

	// no acceptance outside run
	noAcceptIdle: assert property (@(posedge clock) disable iff (!rstN)
		(state != csRun) |-> !accept);

	// quiet claims an empty pipe, checked against the counter
	quietEmpty: assert property (@(posedge clock) disable iff (!rstN)
		quiet |-> (count == '0));

endmodule

// ==== logic/fmulPkg.sv ====
// fp multiply unit shared types
// rounding modes, exception flags, stage sideband and issue states
package fmulPkg;

	// ieee rounding direction, encoding fixed for the sequencer
	typedef enum logic [1:0]
	{
		rmNearestEven = 2'd0,
		rmTowardZero  = 2'd1,
		rmTowardPos   = 2'd2,
		rmTowardNeg   = 2'd3
	} roundMode_t;

	// exception flags reported alongside each result
	typedef struct packed
	{
		logic invalid;
		logic overflow;
		logic underflow;
		logic inexact;
	} fmulFlags_t;

	// result class decided by the operands alone
	typedef enum logic [1:0]
	{
		skNormal,
		skZero,
		skInf,
		skNan
	} specialKind_t;

	// stage 1 info needed again by the rounding stage
	typedef struct packed
	{
		logic               sign;
		// biased exponent sum minus bias, may go negative
		logic signed [12:0] expSum;
		roundMode_t         mode;
		specialKind_t       kind;
		logic               invalid;
	} fmulSide_t;

	// issue control states
	typedef enum logic [1:0]
	{
		csRun,
		csDrain,
		csQuiet
	} ctrlState_t;

endpackage

// ==== logic/fmulProduct.sv ====
// fp multiply front end, stages 1 and 2
// operand decode, special classes, partial products and their exact sum
`timescale 1ns/1ps
`include "fmulUnit_params.svh"

module fmulProduct (
	input  logic                    clock,
	input  logic                    rstN,
	input  logic                    hold,
	input  logic [63:0]             opA,
	input  logic [63:0]             opB,
	input  fmulPkg::roundMode_t     mode,
	output fmulPkg::fmulSide_t      side,
	output logic [`FMUL_PROD_W-1:0] product
);
	import fmulPkg::*;

	// stage 1 decode
	logic [10:0] expA;
	logic [10:0] expB;
	logic [53:0] sigA;
	logic [53:0] sigB;
	logic        zeroA;
	logic        zeroB;
	logic        infA;
	logic        infB;
	logic        nanA;
	logic        nanB;
	fmulSide_t   sideNext;

	// nine 18x18 partial products, index 3*i+j is a[i] * b[j]
	logic [35:0] ppNext [9];
	logic [35:0] ppReg [9];

	// stage 2 adder tree
	logic [`FMUL_PROD_W-1:0] ppWide;
	logic [`FMUL_PROD_W-1:0] sumWide;

	always_comb
	begin
		expA = opA[62:52];
		expB = opB[62:52];
		// hidden one, top bit pads the split to 3 x 18
		sigA = {2'b01, opA[51:0]};
		sigB = {2'b01, opB[51:0]};

		// exponent 0 counts as zero, denormals flushed
		zeroA = (expA == 11'd0);
		zeroB = (expB == 11'd0);
		infA  = (expA == 11'h7FF) && (opA[51:0] == 52'd0);
		infB  = (expB == 11'h7FF) && (opB[51:0] == 52'd0);
		nanA  = (expA == 11'h7FF) && (opA[51:0] != 52'd0);
		nanB  = (expB == 11'h7FF) && (opB[51:0] != 52'd0);

		sideNext.sign = opA[63] ^ opB[63];
		// wraps into a signed 13 bit value
		sideNext.expSum = {2'b00, expA} + {2'b00, expB} - 13'(`FMUL_BIAS);
		sideNext.mode = mode;
		// only zero times inf is invalid
		sideNext.invalid = (zeroA && infB) || (infA && zeroB);

		if (nanA || nanB || sideNext.invalid)
			sideNext.kind = skNan;
		else if (infA || infB)
			sideNext.kind = skInf;
		else if (zeroA || zeroB)
			sideNext.kind = skZero;
		else
			sideNext.kind = skNormal;

		for (int i = 0; i < 3; i++)
		begin
			for (int j = 0; j < 3; j++)
			begin
				ppNext[3 * i + j] = sigA[18 * i +: 18] * sigB[18 * j +: 18];
			end
		end
	end

	// sideband leaves with the stage 1 registers
	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
			side <= '0;
		else if (!hold)
			side <= sideNext;
	end

	always_ff @(posedge clock)
	begin
		if (!hold)
			ppReg <= ppNext;
	end

	// weight of a[i] * b[j] is 2^(18*(i+j))
	always_comb
	begin
		sumWide = '0;
		ppWide = '0;
		for (int i = 0; i < 3; i++)
		begin
			for (int j = 0; j < 3; j++)
			begin
				ppWide = '0;
				ppWide[35:0] = ppReg[3 * i + j];
				sumWide = sumWide + (ppWide << (18 * (i + j)));
			end
		end
	end

	// stage 2, exact product
	always_ff @(posedge clock)
	begin
		if (!hold)
			product <= sumWide;
	end

endmodule

// ==== logic/fmulRound.sv ====
// fp multiply back end, stages 3 and 4
// normalize, round by mode, range checks, result and flag packing
`timescale 1ns/1ps
`include "fmulUnit_params.svh"

module fmulRound (
	input  logic                    clock,
	input  logic                    rstN,
	input  logic                    hold,
	input  fmulPkg::fmulSide_t      side,
	input  logic [`FMUL_PROD_W-1:0] product,
	output logic [63:0]             result,
	output fmulPkg::fmulFlags_t     flags
);
	import fmulPkg::*;

	// stage 3
	logic        normNext;
	logic [52:0] sigNext;
	logic        guardNext;
	logic        stickyNext;
	logic        normReg;
	logic [52:0] sigReg;
	logic        guardReg;
	logic        stickyReg;

	// stage 4
	logic               inexactRaw;
	logic               roundUp;
	logic [53:0]        sigRounded;
	logic [51:0]        fracFinal;
	logic signed [13:0] expFinal;
	logic [63:0]        resultNext;
	fmulFlags_t         flagsNext;

	// product is in [1,4), bit 105 picks the binade
	always_comb
	begin
		normNext = product[105];
		if (normNext)
		begin
			sigNext    = product[105:53];
			guardNext  = product[52];
			stickyNext = |product[51:0];
		end
		else
		begin
			sigNext    = product[104:52];
			guardNext  = product[51];
			stickyNext = |product[50:0];
		end
	end

	always_ff @(posedge clock)
	begin
		if (!hold)
		begin
			normReg   <= normNext;
			sigReg    <= sigNext;
			guardReg  <= guardNext;
			stickyReg <= stickyNext;
		end
	end

	// sideband from the pipe lines up with the stage 3 registers
	always_comb
	begin
		inexactRaw = guardReg | stickyReg;
		case (side.mode)
			rmNearestEven: roundUp = guardReg & (stickyReg | sigReg[0]);
			rmTowardZero:  roundUp = 1'b0;
			rmTowardPos:   roundUp = ~side.sign & inexactRaw;
			rmTowardNeg:   roundUp = side.sign & inexactRaw;
			default:       roundUp = 1'b0;
		endcase

		sigRounded = {1'b0, sigReg} + {53'd0, roundUp};
		// carry out means significand became exactly 2.0
		fracFinal = sigRounded[53] ? sigRounded[52:1] : sigRounded[51:0];
		expFinal = $signed({side.expSum[12], side.expSum}) + $signed({13'd0, normReg})
			+ $signed({13'd0, sigRounded[53]});

		flagsNext = '0;
		case (side.kind)
			skNan:
			begin
				resultNext = `FMUL_QNAN;
				flagsNext.invalid = side.invalid;
			end
			skInf:
				resultNext = {side.sign, 11'h7FF, 52'd0};
			skZero:
				resultNext = {side.sign, 63'd0};
			default:
			begin
				if (expFinal >= 14'sd2047)
				begin
					// overflow to signed inf in every mode
					resultNext = {side.sign, 11'h7FF, 52'd0};
					flagsNext.overflow = 1'b1;
					flagsNext.inexact = 1'b1;
				end
				else if (expFinal <= 14'sd0)
				begin
					// no denormal results, flush
					resultNext = {side.sign, 63'd0};
					flagsNext.underflow = 1'b1;
					flagsNext.inexact = 1'b1;
				end
				else
				begin
					resultNext = {side.sign, expFinal[10:0], fracFinal};
					flagsNext.inexact = inexactRaw;
				end
			end
		endcase
	end

	// stage 4, outputs hold their value under hold
	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			result <= '0;
			flags  <= '0;
		end
		else if (!hold)
		begin
			result <= resultNext;
			flags  <= flagsNext;
		end
	end

endmodule

// ==== logic/fmulUnit.sv ====
// double precision multiply unit, four stage pipeline
// issue control, occupancy count, valid and sideband pipes, datapath
`timescale 1ns/1ps
`include "fmulUnit_params.svh"

module fmulUnit (
	input  logic                clock,
	input  logic                rstN,
	input  logic                start,
	input  logic [63:0]         opA,
	input  logic [63:0]         opB,
	input  fmulPkg::roundMode_t mode,
	input  logic                hold,
	input  logic                quiesce,
	output logic [63:0]         result,
	output fmulPkg::fmulFlags_t flags,
	output logic                done,
	output logic                ready,
	output logic                quiet
);
	import fmulPkg::*;

	logic                     accept;
	logic [`FMUL_COUNT_W-1:0] count;
	logic                     validTail;
	fmulSide_t                sideHead;
	fmulSide_t                sideTail;
	logic [`FMUL_PROD_W-1:0]  product;

	fmulIssueCtrl u_fmulIssueCtrl (
		.clock   (clock),
		.rstN    (rstN),
		.start   (start),
		.hold    (hold),
		.quiesce (quiesce),
		.count   (count),
		.accept  (accept),
		.ready   (ready),
		.quiet   (quiet)
	);

	inflightCounter u_inflightCounter (
		.clock (clock),
		.rstN  (rstN),
		.hold  (hold),
		.inc   (accept),
		.dec   (done),
		.count (count)
	);

	// one valid bit per stage, tail lines up with the result register
	holdPipe #(
		.payloadT (logic),
		.depth    (`FMUL_LATENCY)
	) u_validPipe (
		.clock (clock),
		.rstN  (rstN),
		.hold  (hold),
		.din   (accept),
		.dout  (validTail)
	);

	// tail stays set under hold, pulse only on a moving edge
	assign done = validTail & ~hold;

	// carries stage 1 info past the adder tree and normalize stage
	holdPipe #(
		.payloadT (fmulSide_t),
		.depth    (`FMUL_SIDE_DEPTH)
	) u_sidePipe (
		.clock (clock),
		.rstN  (rstN),
		.hold  (hold),
		.din   (sideHead),
		.dout  (sideTail)
	);

	fmulProduct u_fmulProduct (
		.clock   (clock),
		.rstN    (rstN),
		.hold    (hold),
		.opA     (opA),
		.opB     (opB),
		.mode    (mode),
		.side    (sideHead),
		.product (product)
	);

	fmulRound u_fmulRound (
		.clock   (clock),
		.rstN    (rstN),
		.hold    (hold),
		.side    (sideTail),
		.product (product),
		.result  (result),
		.flags   (flags)
	);

endmodule

// ==== logic/fmulUnit_params.svh ====
// fp multiply unit constants
// pipeline latency, stage depths, widths and the canonical nan
`ifndef FMUL_UNIT_PARAMS_SVH
`define FMUL_UNIT_PARAMS_SVH

// non-held cycles from accept to done
`define FMUL_LATENCY 4

// sideband stages between product and round blocks
`define FMUL_SIDE_DEPTH 2

// in-flight count width, must hold FMUL_LATENCY
`define FMUL_COUNT_W 3

// exact significand product width, 53 x 53 bits
`define FMUL_PROD_W 106

// double precision exponent bias
`define FMUL_BIAS 1023

// quiet nan, positive, top fraction bit only
`define FMUL_QNAN 64'h7FF8_0000_0000_0000

`endif

// ==== logic/holdPipe.sv ====
// stallable delay line for any payload type
// shifts on every edge without hold, several entries in flight
`timescale 1ns/1ps

module holdPipe #(
	parameter type payloadT = logic,
	parameter int  depth    = 2
) (
	input  logic    clock,
	input  logic    rstN,
	input  logic    hold,
	input  payloadT din,
	output payloadT dout
);

	// stage 0 takes din, last stage drives dout
	payloadT stages [depth];

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
		begin
			// clear every entry so nothing looks valid
			for (int i = 0; i < depth; i++)
			begin
				stages[i] <= '0;
			end
		end
		else if (!hold)
		begin
			stages[0] <= din;
			// move every entry one step on
			for (int i = 1; i < depth; i++)
			begin
				stages[i] <= stages[i - 1];
			end
		end
	end

	// oldest entry
	assign dout = stages[depth - 1];

endmodule

// ==== logic/inflightCounter.sv ====
// occupancy counter for the multiply pipeline
// up on accept, down on done, frozen by hold
`timescale 1ns/1ps
`include "fmulUnit_params.svh"

module inflightCounter (
	input  logic                     clock,
	input  logic                     rstN,
	input  logic                     hold,
	input  logic                     inc,
	input  logic                     dec,
	output logic [`FMUL_COUNT_W-1:0] count
);

	always_ff @(posedge clock or negedge rstN)
	begin
		if (!rstN)
			count <= '0;
		else if (!hold)
		begin
			case ({inc, dec})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				// both or neither, no change
				default: count <= count;
			endcase
		end
	end

	// pipe holds at most one op per stage
	countBound: assert property (@(posedge clock) disable iff (!rstN)
		count <= `FMUL_LATENCY);

	// a done with nothing in flight means the valid pipe and counter disagree
	noEmptyDone: assert property (@(posedge clock) disable iff (!rstN)
		dec |-> (count != '0));

endmodule

// ==== run.sh ====
#!/bin/sh
# build the multiply unit testbench with Verilator, run it, then check the log
rm -f sim.log
verilator --binary --timing --assert -f all.f --top-module fmulUnitTb -o fmulSim \
	&& ./obj_dir/fmulSim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "All tests passed!" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }
